// File: arrayMemory_macros.svh
//--------------------------------------
// Widths, depths and credit counts of the array memory unit.
// Include in any file that sizes a port, a table or a credit counter.
//--------------------------------------
`ifndef ARRAY_MEMORY_MACROS_SVH
`define ARRAY_MEMORY_MACROS_SVH

//--------------------------------------
// Element and array geometry
//--------------------------------------
`define AM_DATA_BITS    16                      // Element width
`define AM_INDEX_BITS   3                       // Index width, 8 elements per array
`define AM_ARRAY_BITS   2                       // Array number width, 4 arrays
`define AM_SIZE_BITS    (`AM_INDEX_BITS + 1)    // Length 0 to 8 needs one bit more
`define AM_ELEMENTS     (1 << `AM_INDEX_BITS)   // Elements per array
`define AM_ARRAYS       (1 << `AM_ARRAY_BITS)   // Number of arrays

//--------------------------------------
// Flow control
//--------------------------------------
`define AM_REQ_DEPTH    4                       // Request buffer entries, sender credits
`define AM_REQ_PTR_BITS 2                       // Request buffer pointer width
`define AM_REQ_CNT_BITS 3                       // Occupancy 0 to 4
`define AM_RSP_CREDITS  2                       // Response credits after reset
`define AM_RSP_CNT_BITS 2                       // Credit count 0 to 2

`endif

// File: arrayMemoryPkg.sv
//--------------------------------------
// Types shared by the array memory unit and its testbench.
// Opcodes, request and response words, controller states.
//--------------------------------------
`include "arrayMemory_macros.svh"

package arrayMemoryPkg;

  //--------------------------------------
  // Opcodes
  //--------------------------------------
  typedef enum logic [3:0] {
    opClear,                                    // Zero every length
    opWrite,                                    // Store element, grow length
    opRead,                                     // Fetch element
    opSize,                                     // Report length
    opInc,                                      // Length plus one
    opDec,                                      // Length minus one
    opPush,                                     // Append element
    opPop,                                      // Remove last element
    opResize,                                   // Set length from data
    opIndex,                                    // Last match position plus one
    opLess,                                     // Count below key
    opGreater                                   // Count above key
  } arrayOp_t;

  //--------------------------------------
  // Channel words
  //--------------------------------------
  typedef struct packed {
    arrayOp_t                  op;
    logic [`AM_ARRAY_BITS-1:0] array;
    logic [`AM_INDEX_BITS-1:0] index;
    logic [`AM_DATA_BITS-1:0]  data;
  } arrayReq_t;

  typedef struct packed {
    logic [`AM_DATA_BITS-1:0] value;
    logic                     ok;           // Low when a bound stopped the operation
  } arrayRsp_t;

  typedef enum logic [1:0] {
    stateIdle,                                  // Wait for a request
    stateExecute,                               // Drive tables for one cycle
    stateScan,                                  // Scanner stepping
    stateRespond                                // Hold response until a credit is free
  } ctrlState_t;

endpackage

// File: arrayRequestFifo.sv
//--------------------------------------
// Request buffer behind the credit channel.
// Each popped entry hands one credit back to the sender.
//--------------------------------------
`timescale 1ns/1ns
`include "arrayMemory_macros.svh"

module arrayRequestFifo import arrayMemoryPkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  logic      reqValid,
  input  arrayReq_t req,
  input  logic      pop,
  output logic      headValid,
  output arrayReq_t head,
  output logic      reqCredit
);

  arrayReq_t                   entries [`AM_REQ_DEPTH];
  logic [`AM_REQ_PTR_BITS-1:0] writePtr;
  logic [`AM_REQ_PTR_BITS-1:0] readPtr;
  logic [`AM_REQ_CNT_BITS-1:0] count;
  logic                        take;

  assign headValid = count != '0;
  assign head      = entries[readPtr];
  assign take      = pop && headValid;
  assign reqCredit = take;                      // Credit leaves with the entry

  always_ff @(posedge clock) begin
    if (reset) begin
      writePtr <= '0;
      readPtr  <= '0;
      count    <= '0;
    end else begin
      if (reqValid) begin
        writePtr <= writePtr + 1'b1;            // Depth is a power of two
      end
      if (take) begin
        readPtr <= readPtr + 1'b1;
      end
      case ({reqValid, take})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (reqValid) begin
      entries[writePtr] <= req;
    end
  end

  // A full buffer means the sender spent a credit it never held
  assert property (@(posedge clock) disable iff (reset)
    !(reqValid && count == `AM_REQ_DEPTH))
    else $error("request arrived with the buffer full");

  assert property (@(posedge clock) disable iff (reset) !(pop && !headValid))
    else $error("pop with the buffer empty");

endmodule

// File: arraySizeTable.sv
//--------------------------------------
// Current length of every array and the rules that change it.
// All bound checks on lengths are made here.
//--------------------------------------
`timescale 1ns/1ns
`include "arrayMemory_macros.svh"

module arraySizeTable import arrayMemoryPkg::*; (
  input  logic                      clock,
  input  logic                      reset,
  input  arrayOp_t                  sizeOp,
  input  logic                      sizeEnable,
  input  logic [`AM_ARRAY_BITS-1:0] array,
  input  logic [`AM_INDEX_BITS-1:0] index,
  input  logic [`AM_DATA_BITS-1:0]  data,
  output logic [`AM_SIZE_BITS-1:0]  size,
  output logic                      canPush,
  output logic                      canPop
);

  logic [`AM_SIZE_BITS-1:0] sizes [`AM_ARRAYS];
  logic [`AM_SIZE_BITS-1:0] written;

  assign size    = sizes[array];
  assign canPush = size < `AM_ELEMENTS;         // Room for one more
  assign canPop  = size != '0;
  assign written = {1'b0, index} + 1'b1;        // Length implied by a write

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int a = 0; a < `AM_ARRAYS; a++) begin
        sizes[a] <= '0;
      end
    end else if (sizeEnable) begin
      case (sizeOp)
        opClear: begin
          for (int a = 0; a < `AM_ARRAYS; a++) begin
            sizes[a] <= '0;
          end
        end
        opWrite:  if (written > size) sizes[array] <= written;
        opInc:    if (canPush) sizes[array] <= size + 1'b1;
        opPush:   if (canPush) sizes[array] <= size + 1'b1;
        opDec:    if (canPop) sizes[array] <= size - 1'b1;
        opPop:    if (canPop) sizes[array] <= size - 1'b1;
        opResize: if (data <= `AM_ELEMENTS) sizes[array] <= data[`AM_SIZE_BITS-1:0];
        default:  sizes[array] <= size;
      endcase
    end
  end

  for (genvar a = 0; a < `AM_ARRAYS; a++) begin : gLimit
    assert property (@(posedge clock) disable iff (reset) sizes[a] <= `AM_ELEMENTS)
      else $error("array %0d length above capacity", a);
  end

endmodule

// File: arrayDataStore.sv
//--------------------------------------
// Element storage for all arrays, addressed by array and index.
// One clocked write port, one combinational read port.
//--------------------------------------
`timescale 1ns/1ns
`include "arrayMemory_macros.svh"

module arrayDataStore (
  input  logic                      clock,
  input  logic                      writeEnable,
  input  logic [`AM_ARRAY_BITS-1:0] array,
  input  logic [`AM_INDEX_BITS-1:0] index,
  input  logic [`AM_DATA_BITS-1:0]  writeData,
  output logic [`AM_DATA_BITS-1:0]  readData
);

  //--------------------------------------
  // Storage, fixed block per array
  //--------------------------------------
  logic [`AM_DATA_BITS-1:0] memory [`AM_ARRAYS][`AM_ELEMENTS];

  always_ff @(posedge clock) begin
    if (writeEnable) begin
      memory[array][index] <= writeData;
    end
  end

  // Same address serves read and write, the controller never needs both at once
  assign readData = memory[array][index];

endmodule

// File: arrayScanner.sv
//--------------------------------------
// Walks the live part of one array, one element per clock.
// Finds the last match, or counts elements below or above the key.
//--------------------------------------
`timescale 1ns/1ns
`include "arrayMemory_macros.svh"

module arrayScanner import arrayMemoryPkg::*; (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      start,
  input  arrayOp_t                  kind,
  input  logic [`AM_DATA_BITS-1:0]  key,
  input  logic [`AM_SIZE_BITS-1:0]  size,
  input  logic [`AM_DATA_BITS-1:0]  element,
  output logic [`AM_INDEX_BITS-1:0] scanIndex,
  output logic                      busy,
  output logic                      done,
  output logic [`AM_SIZE_BITS-1:0]  result
);

  arrayOp_t                  scanKind;
  logic [`AM_DATA_BITS-1:0]  scanKey;
  logic [`AM_INDEX_BITS-1:0] lastIndex;
  logic                      lastStep;

  assign lastStep = scanIndex == lastIndex;

  //--------------------------------------
  // Control
  //--------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      busy      <= 1'b0;
      done      <= 1'b0;
      scanIndex <= '0;
    end else begin
      done <= 1'b0;
      if (start) begin
        busy      <= size != '0;
        done      <= size == '0;                // Empty array finishes at once
        scanIndex <= '0;
      end else if (busy) begin
        scanIndex <= scanIndex + 1'b1;
        if (lastStep) begin
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

  //--------------------------------------
  // Compare and accumulate
  //--------------------------------------
  always_ff @(posedge clock) begin
    if (start) begin
      scanKind  <= kind;
      scanKey   <= key;
      lastIndex <= size[`AM_INDEX_BITS-1:0] - 1'b1;   // Size 8 wraps to 7
      result    <= '0;
    end else if (busy) begin
      case (scanKind)
        opIndex:   if (element == scanKey) result <= {1'b0, scanIndex} + 1'b1;
        opLess:    if (element < scanKey) result <= result + 1'b1;
        opGreater: if (element > scanKey) result <= result + 1'b1;
        default:   result <= result;
      endcase
    end
  end

  // Controller must wait for done before the next scan
  assert property (@(posedge clock) disable iff (reset) !(start && busy))
    else $error("scan started while busy");

endmodule

// File: arrayOpController.sv
//--------------------------------------
// Takes requests from the buffer, runs them against the tables
// and the scanner, and returns one response each under credits.
//--------------------------------------
`timescale 1ns/1ns
`include "arrayMemory_macros.svh"

module arrayOpController import arrayMemoryPkg::*; (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      headValid,
  input  arrayReq_t                 head,
  output logic                      pop,
  output arrayReq_t                 current,
  input  logic [`AM_SIZE_BITS-1:0]  size,
  input  logic                      canPush,
  input  logic                      canPop,
  output arrayOp_t                  sizeOp,
  output logic                      sizeEnable,
  output logic                      storeWrite,
  output logic [`AM_INDEX_BITS-1:0] storeIndex,
  input  logic [`AM_DATA_BITS-1:0]  readData,
  output logic                      scanStart,
  input  logic [`AM_INDEX_BITS-1:0] scanIndex,
  input  logic                      scanBusy,
  input  logic                      scanDone,
  input  logic [`AM_SIZE_BITS-1:0]  scanResult,
  input  logic                      rspCredit,
  output logic                      rspValid,
  output arrayRsp_t                 rsp
);

  ctrlState_t                   state;
  logic [`AM_DATA_BITS-1:0]     value;
  logic                         ok;
  logic [`AM_RSP_CNT_BITS-1:0]  credits;
  logic                         isScan;
  logic                         changesSize;
  logic                         reportsSize;
  logic [`AM_DATA_BITS-1:0]     sizeWide;
  logic                         executing;

  assign isScan      = current.op inside {opIndex, opLess, opGreater};
  assign changesSize = current.op inside {opClear, opWrite, opInc, opDec, opPush, opPop, opResize};
  assign reportsSize = current.op inside {opClear, opSize, opInc, opDec, opPush, opResize};
  assign sizeWide    = {{(`AM_DATA_BITS - `AM_SIZE_BITS){1'b0}}, size};
  assign executing   = state == stateExecute;

  assign pop        = state == stateIdle && headValid;
  assign sizeOp     = current.op;
  assign sizeEnable = executing && changesSize;
  assign storeWrite = executing && (current.op == opWrite || (current.op == opPush && canPush));
  assign scanStart  = executing && isScan;
  assign rspValid   = state == stateRespond && credits != '0;

  //--------------------------------------
  // Store address steering
  //--------------------------------------
  always_comb begin
    storeIndex = current.index;
    if (scanBusy) begin
      storeIndex = scanIndex;
    end else if (current.op == opPush) begin
      storeIndex = size[`AM_INDEX_BITS-1:0];    // Slot after the last element
    end else if (current.op == opPop) begin
      storeIndex = size[`AM_INDEX_BITS-1:0] - 1'b1;
    end
  end

  always_comb begin
    rsp.value = reportsSize ? sizeWide : value;
    rsp.ok    = ok;
    if (current.op == opResize) begin
      rsp.ok = sizeWide == current.data;        // Length only follows data when it fit
    end
  end

  //--------------------------------------
  // State machine and response credits
  //--------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      state   <= stateIdle;
      credits <= `AM_RSP_CREDITS;
    end else begin
      case (state)
        stateIdle:    if (headValid) state <= stateExecute;
        stateExecute: state <= isScan ? stateScan : stateRespond;
        stateScan:    if (scanDone) state <= stateRespond;
        stateRespond: if (rspValid) state <= stateIdle;
        default:      state <= stateIdle;
      endcase
      case ({rspCredit, rspValid})
        2'b10:   credits <= credits + 1'b1;
        2'b01:   credits <= credits - 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (pop) begin
      current <= head;
    end
    if (executing) begin
      case (current.op)
        opWrite: value <= current.data;
        opRead:  value <= readData;
        opPop:   value <= canPop ? readData : '0;
        default: value <= '0;
      endcase
      case (current.op)
        opInc, opPush: ok <= canPush;
        opDec, opPop:  ok <= canPop;
        default:       ok <= 1'b1;
      endcase
    end
    if (state == stateScan && scanDone) begin
      value <= {{(`AM_DATA_BITS - `AM_SIZE_BITS){1'b0}}, scanResult};
    end
  end

  // Receiver must not return more credits than it was given
  assert property (@(posedge clock) disable iff (reset) credits <= `AM_RSP_CREDITS)
    else $error("response credits above limit");

endmodule

// File: arrayMemory.sv
//--------------------------------------
// Array memory unit, top level.
// Credit-based request and response channels around the controller.
//--------------------------------------
`timescale 1ns/1ns
`include "arrayMemory_macros.svh"

module arrayMemory import arrayMemoryPkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  logic      reqValid,
  input  arrayReq_t req,
  output logic      reqCredit,
  output logic      rspValid,
  output arrayRsp_t rsp,
  input  logic      rspCredit
);

  arrayReq_t                 head;
  arrayReq_t                 current;           // Request under execution
  logic                      headValid;
  logic                      pop;
  arrayOp_t                  sizeOp;
  logic                      sizeEnable;
  logic [`AM_SIZE_BITS-1:0]  size;
  logic                      canPush;
  logic                      canPop;
  logic                      storeWrite;
  logic [`AM_INDEX_BITS-1:0] storeIndex;
  logic [`AM_DATA_BITS-1:0]  readData;
  logic                      scanStart;
  logic [`AM_INDEX_BITS-1:0] scanIndex;
  logic                      scanBusy;
  logic                      scanDone;
  logic [`AM_SIZE_BITS-1:0]  scanResult;

  arrayRequestFifo i_fifo (
    .clock, .reset, .reqValid, .req, .pop, .headValid, .head, .reqCredit
  );

  arrayOpController i_ctrl (
    .clock, .reset, .headValid, .head, .pop, .current, .size, .canPush, .canPop,
    .sizeOp, .sizeEnable, .storeWrite, .storeIndex, .readData, .scanStart,
    .scanIndex, .scanBusy, .scanDone, .scanResult, .rspCredit, .rspValid, .rsp
  );

  arraySizeTable i_sizes (
    .clock, .reset, .sizeOp, .sizeEnable,
    .array(current.array), .index(current.index), .data(current.data),
    .size, .canPush, .canPop
  );

  arrayDataStore i_store (
    .clock, .writeEnable(storeWrite), .array(current.array), .index(storeIndex),
    .writeData(current.data), .readData
  );

  arrayScanner i_scan (
    .clock, .reset, .start(scanStart), .kind(current.op), .key(current.data),
    .size, .element(readData), .scanIndex, .busy(scanBusy), .done(scanDone),
    .result(scanResult)
  );

endmodule

// File: arrayMemoryTb.sv
//--------------------------------------
// Testbench for the array memory unit. Replays the test data file
// through both credit channels and checks every response in order.
//--------------------------------------
`timescale 1ns/1ns
`include "arrayMemory_macros.svh"

module arrayMemoryTb import arrayMemoryPkg::*; ();

  logic        clock;
  logic        reset;
  logic        reqValid;
  arrayReq_t   req;
  logic        reqCredit;
  logic        rspValid;
  arrayRsp_t   rsp;
  logic        rspCredit;

  arrayReq_t   requests [$];                    // File order
  arrayRsp_t   expected [$];
  int          groups [$];
  int          pending [$];                     // Requests still waiting for a response
  longint      creditDue [$];                   // Cycle when each held credit goes back
  string       groupNames [5] = '{"write and read", "push and pop", "length bounds",
                                  "scans", "back-pressure"};
  int          lineCount;
  int          sent;
  int          received;
  int          reqCredits;
  int          idx;
  longint      cycle;
  int unsigned seed;
  int          checks;
  int          errors;
  int          groupChecks;
  int          groupErrors;

  arrayMemory i_dut (
    .clock, .reset, .reqValid, .req, .reqCredit, .rspValid, .rsp, .rspCredit
  );

  initial clock = 1'b0;
  always #50 clock = ~clock;                    // 100 ns period

  //--------------------------------------
  // Helpers
  //--------------------------------------
  function automatic int unsigned nextRandom();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed >> 16;                          // Upper bits are the better ones
  endfunction

  task automatic compare(input logic [31:0] actual, input logic [31:0] wanted,
                         input string what);
    checks++;
    groupChecks++;
    if (actual !== wanted) begin
      errors++;
      groupErrors++;
      $display("error at %0t ns: %s is %0h, expected %0h", $time, what, actual, wanted);
    end
  endtask

  task automatic reportGroup(input int group);
    $display("group %0d, %s: %0d checks, %0d errors", group, groupNames[group-1],
             groupChecks, groupErrors);
    groupChecks = 0;
    groupErrors = 0;
  endtask

  task automatic loadTests();
    int        fd;
    string     line;
    int        g, op, ar, ix, dt, ev, eo;
    arrayReq_t r;
    arrayRsp_t e;
    fd = $fopen("arrayMemory_testdata.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open the test data file");
    end else begin
      while ($fgets(line, fd) > 0) begin
        if (line.len() > 0 && line[0] != "#" &&
            $sscanf(line, "%h %h %h %h %h %h %h", g, op, ar, ix, dt, ev, eo) == 7) begin
          r.op    = arrayOp_t'(op[3:0]);
          r.array = ar[`AM_ARRAY_BITS-1:0];
          r.index = ix[`AM_INDEX_BITS-1:0];
          r.data  = dt[`AM_DATA_BITS-1:0];
          e.value = ev[`AM_DATA_BITS-1:0];
          e.ok    = eo[0];
          requests.push_back(r);
          expected.push_back(e);
          groups.push_back(g);
        end
      end
      $fclose(fd);
    end
    lineCount = requests.size();
  endtask

  //--------------------------------------
  // Sender and receiver, both credit sides
  //--------------------------------------
  always @(posedge clock) begin
    if (reset) begin
      reqValid   <= 1'b0;
      rspCredit  <= 1'b0;
      reqCredits = `AM_REQ_DEPTH;
    end else begin
      cycle++;
      if (reqValid) reqCredits--;               // Valid cycle just ended
      if (reqCredit) reqCredits++;
      if (reqCredit) begin
        compare(reqCredits <= `AM_REQ_DEPTH, 1, "request credits within depth");
      end
      reqValid <= 1'b0;
      if (sent < lineCount && reqCredits > 0) begin
        reqValid <= 1'b1;
        req      <= requests[sent];
        pending.push_back(sent);
        sent++;
      end
      if (rspValid) begin
        if (pending.size() == 0) begin
          errors++;
          $display("a response arrived with no request outstanding");
        end else begin
          idx = pending.pop_front();
          compare(rsp.value, expected[idx].value, $sformatf("value of request %0d", idx));
          compare(rsp.ok, expected[idx].ok, $sformatf("ok of request %0d", idx));
          received++;
          // Back-pressure group holds its credits much longer
          creditDue.push_back(cycle + nextRandom() % 6 + (groups[idx] == 5 ? 24 : 0));
          if (idx == lineCount - 1 || groups[idx+1] != groups[idx]) begin
            reportGroup(groups[idx]);
          end
        end
      end
      rspCredit <= 1'b0;
      if (creditDue.size() > 0 && creditDue[0] <= cycle) begin
        rspCredit <= 1'b1;
        void'(creditDue.pop_front());
      end
    end
  end

  //--------------------------------------
  // Run control
  //--------------------------------------
  initial begin
    reset     = 1'b1;
    reqValid  = 1'b0;
    req       = '0;
    rspCredit = 1'b0;
    seed      = 18;
    loadTests();
    repeat (3) @(posedge clock);
    reset <= 1'b0;
    wait (received == lineCount);
    repeat (4) @(posedge clock);
    compare(reqCredits, `AM_REQ_DEPTH, "request credits after drain");
    $display("%0d responses, %0d checks, %0d errors", received, checks, errors);
    if (errors == 0 && lineCount > 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    wait (lineCount > 0);
    repeat (lineCount * 20) @(posedge clock);   // Generous bound per request
    $display("responses stopped, only %0d of %0d arrived in time", received, lineCount);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// File: arrayMemory_testdata.txt
# group opcode array index data expected_value expected_ok, all hex
# opcodes 0 clear 1 write 2 read 3 size 4 inc 5 dec 6 push 7 pop 8 resize 9 index a less b greater
1 1 0 2 00a1 00a1 1
1 1 1 7 1234 1234 1
1 1 2 0 beef beef 1
1 1 3 5 0c0d 0c0d 1
1 2 0 2 0000 00a1 1
1 2 2 0 0000 beef 1
1 3 1 0 0000 0008 1
1 3 3 0 0000 0006 1
2 0 0 0 0000 0000 1
2 6 2 0 0011 0001 1
2 6 2 0 0022 0002 1
2 6 2 0 0033 0003 1
2 6 2 0 0044 0004 1
2 6 2 0 0055 0005 1
2 6 2 0 0066 0006 1
2 6 2 0 0077 0007 1
2 6 2 0 0088 0008 1
2 6 2 0 0099 0008 0
2 7 2 0 0000 0088 1
2 7 2 0 0000 0077 1
2 7 2 0 0000 0066 1
2 7 2 0 0000 0055 1
2 7 2 0 0000 0044 1
2 7 2 0 0000 0033 1
2 7 2 0 0000 0022 1
2 7 2 0 0000 0011 1
2 7 2 0 0000 0000 0
3 5 0 0 0000 0000 0
3 4 0 0 0000 0001 1
3 8 1 0 0009 0000 0
3 8 1 0 0008 0008 1
3 4 1 0 0000 0008 0
3 0 2 0 0000 0000 1
3 3 1 0 0000 0000 1
4 9 2 0 0011 0000 1
4 8 2 0 0005 0005 1
4 1 2 1 0055 0055 1
4 9 2 0 0055 0005 1
4 9 2 0 0077 0000 1
4 a 2 0 0040 0002 1
4 b 2 0 0040 0003 1
5 8 2 0 0008 0008 1
5 b 2 0 0050 0005 1
5 a 2 0 0050 0003 1
5 2 2 3 0000 0044 1
5 7 2 0 0000 0088 1
5 9 2 0 0088 0000 1

// File: arrayMemory.f
+incdir+.
arrayMemoryPkg.sv
arrayRequestFifo.sv
arraySizeTable.sv
arrayDataStore.sv
arrayScanner.sv
arrayOpController.sv
arrayMemory.sv
arrayMemoryTb.sv
